/* hdl/lsq_pkg.sv */
package lsq_pkg;

    // queue sizes
    localparam int LDQ_DEPTH = 4;
    localparam int STQ_DEPTH = 4;
    localparam int LDQ_IDX_W = $clog2(LDQ_DEPTH);
    localparam int STQ_PTR_W = $clog2(STQ_DEPTH);

    // core-side widths
    localparam int ROB_W  = 5;
    localparam int PHYS_W = 6;
    localparam int ARCH_W = 5;

    // rv32 opcodes handled here
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // access size codes, shared by loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // names an entry from enqueue until its address arrives
    // both queues use a 2-bit index
    typedef struct packed {
        logic                 is_store;
        logic [LDQ_IDX_W-1:0] idx;
    } lsq_tag_t;

    typedef struct packed {
        logic              valid;
        logic [6:0]        opcode;
        logic [2:0]        funct3;
        logic [ROB_W-1:0]  rob_num;
        logic [PHYS_W-1:0] pd;
        logic [ARCH_W-1:0] rd;
    } dispatch_t;

    // from the address adder
    typedef struct packed {
        logic        valid;
        lsq_tag_t    tag;
        logic [31:0] addr;
        logic [31:0] wdata;
    } addr_fill_t;

    typedef struct packed {
        logic              valid;
        logic              addr_ready;
        logic [2:0]        funct3;
        logic [31:0]       addr;
        logic [ROB_W-1:0]  rob_num;
        logic [PHYS_W-1:0] pd;
        logic [ARCH_W-1:0] rd;
        logic [2:0]        store_wait;
    } ldq_entry_t;

    typedef struct packed {
        logic              valid;
        logic              addr_ready;
        logic [2:0]        funct3;
        logic [31:0]       addr;
        logic [31:0]       wdata;
        logic [ROB_W-1:0]  rob_num;
        logic [PHYS_W-1:0] pd;
        logic [ARCH_W-1:0] rd;
        logic [2:0]        load_wait;
    } stq_entry_t;

    // data cache request, held until the response pulse
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic              is_store;
        logic [ROB_W-1:0]  rob_num;
        logic [PHYS_W-1:0] pd;
        logic [ARCH_W-1:0] rd;
        logic [31:0]       value;
    } result_t;

endpackage

/* hdl/load_queue.sv */
`timescale 1ns/10ps

module load_queue
    import lsq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  dispatch_t            disp,
    input  addr_fill_t           fill,
    input  logic                 store_done,
    input  logic                 load_done,
    input  logic [LDQ_IDX_W-1:0] done_idx,
    input  logic [2:0]           stq_count,
    output logic                 ldq_full,
    output logic [LDQ_IDX_W-1:0] alloc_idx,
    output logic                 ready,
    output logic [LDQ_IDX_W-1:0] sel_idx,
    output ldq_entry_t           sel_entry,
    output logic [2:0]           load_count
);

    ldq_entry_t slots [LDQ_DEPTH];
    ldq_entry_t new_entry;
    logic       enq;
    logic       fill_hit;

    assign enq      = disp.valid && (disp.opcode == OP_LOAD) && !ldq_full;
    assign fill_hit = fill.valid && !fill.tag.is_store;

    // lowest free slot; scanning downwards lets slot 0 win
    always_comb
    begin
        ldq_full  = 1'b1;
        alloc_idx = '0;
        for (int i = LDQ_DEPTH - 1; i >= 0; i--)
        begin
            if (!slots[i].valid)
            begin
                ldq_full  = 1'b0;
                alloc_idx = LDQ_IDX_W'(i);
            end
        end
    end

    // lowest slot with an address and no older store left
    always_comb
    begin
        ready   = 1'b0;
        sel_idx = '0;
        for (int i = LDQ_DEPTH - 1; i >= 0; i--)
        begin
            if (slots[i].valid && slots[i].addr_ready && slots[i].store_wait == '0)
            begin
                ready   = 1'b1;
                sel_idx = LDQ_IDX_W'(i);
            end
        end
    end

    assign sel_entry = slots[sel_idx];

    always_comb
    begin
        load_count = '0;
        for (int i = 0; i < LDQ_DEPTH; i++)
        begin
            load_count = load_count + 3'(slots[i].valid);
        end
    end

    // a store finishing this cycle is no longer ahead of the new load
    always_comb
    begin
        new_entry            = '0;
        new_entry.valid      = 1'b1;
        new_entry.funct3     = disp.funct3;
        new_entry.rob_num    = disp.rob_num;
        new_entry.pd         = disp.pd;
        new_entry.rd         = disp.rd;
        new_entry.store_wait = stq_count - {2'b00, store_done};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < LDQ_DEPTH; i++)
            begin
                slots[i].valid <= 1'b0;
            end
        end
        else
        begin
            for (int i = 0; i < LDQ_DEPTH; i++)
            begin
                if (store_done && slots[i].store_wait != '0)
                    slots[i].store_wait <= slots[i].store_wait - 3'd1;
            end
            if (load_done)
                slots[done_idx].valid <= 1'b0;
            if (fill_hit)
            begin
                slots[fill.tag.idx].addr       <= fill.addr;
                slots[fill.tag.idx].addr_ready <= 1'b1;
            end
            if (enq)
                slots[alloc_idx] <= new_entry;
        end
    end

    fill_to_live_slot: assert property (@(posedge clk) disable iff (rst)
        fill_hit |-> slots[fill.tag.idx].valid);

    no_load_when_full: assert property (@(posedge clk) disable iff (rst)
        (disp.valid && disp.opcode == OP_LOAD) |-> !ldq_full);

endmodule

/* hdl/store_queue.sv */
`timescale 1ns/10ps

module store_queue
    import lsq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  dispatch_t            disp,
    input  addr_fill_t           fill,
    input  logic                 load_done,
    input  logic                 store_done,
    input  logic [2:0]           load_count,
    output logic                 stq_full,
    output logic [STQ_PTR_W-1:0] tail_idx,
    output logic                 ready,
    output stq_entry_t           head_entry,
    output logic [2:0]           stq_count
);

    stq_entry_t         fifo [STQ_DEPTH];
    stq_entry_t         new_entry;
    // extra top bit marks the lap
    logic [STQ_PTR_W:0] head;
    logic [STQ_PTR_W:0] tail;
    logic               empty;
    logic               enq;
    logic               fill_hit;

    assign empty    = (head == tail);
    assign stq_full = (head[STQ_PTR_W-1:0] == tail[STQ_PTR_W-1:0])
                   && (head[STQ_PTR_W] != tail[STQ_PTR_W]);
    assign stq_count = 3'(tail - head);
    assign tail_idx  = tail[STQ_PTR_W-1:0];

    assign enq      = disp.valid && (disp.opcode == OP_STORE) && !stq_full;
    assign fill_hit = fill.valid && fill.tag.is_store;

    // only the oldest store may go, once every older load is out
    assign head_entry = fifo[head[STQ_PTR_W-1:0]];
    assign ready      = head_entry.valid && head_entry.addr_ready
                     && (head_entry.load_wait == '0);

    always_comb
    begin
        new_entry           = '0;
        new_entry.valid     = 1'b1;
        new_entry.funct3    = disp.funct3;
        new_entry.rob_num   = disp.rob_num;
        new_entry.pd        = disp.pd;
        new_entry.rd        = disp.rd;
        new_entry.load_wait = load_count - {2'b00, load_done};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < STQ_DEPTH; i++)
            begin
                fifo[i].valid <= 1'b0;
            end
        end
        else
        begin
            for (int i = 0; i < STQ_DEPTH; i++)
            begin
                if (load_done && fifo[i].load_wait != '0)
                    fifo[i].load_wait <= fifo[i].load_wait - 3'd1;
            end
            if (store_done)
            begin
                fifo[head[STQ_PTR_W-1:0]].valid <= 1'b0;
                head <= head + 1'b1;
            end
            if (fill_hit)
            begin
                fifo[fill.tag.idx].addr       <= fill.addr;
                fifo[fill.tag.idx].wdata      <= fill.wdata;
                fifo[fill.tag.idx].addr_ready <= 1'b1;
            end
            if (enq)
            begin
                fifo[tail_idx] <= new_entry;
                tail <= tail + 1'b1;
            end
        end
    end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        store_done |-> !empty);

endmodule

/* hdl/mem_align.sv */
`timescale 1ns/10ps

module mem_align
    import lsq_pkg::*;
(
    input  ldq_entry_t  ld_entry,
    input  stq_entry_t  st_entry,
    input  logic        is_store,
    input  logic [31:0] rdata,
    input  logic [2:0]  resp_funct3,
    input  logic [1:0]  resp_offset,
    output mem_req_t    req,
    output logic [31:0] load_value
);

    logic [31:0] addr;
    logic [2:0]  funct3;
    logic [3:0]  mask;
    logic [7:0]  byte_v;
    logic [15:0] half_v;

    // request side
    always_comb
    begin
        addr   = is_store ? st_entry.addr : ld_entry.addr;
        funct3 = is_store ? st_entry.funct3 : ld_entry.funct3;

        // unsigned codes share the low bits with the signed ones
        unique case (funct3[1:0])
            2'b00:   mask = 4'b0001 << addr[1:0];
            2'b01:   mask = 4'b0011 << addr[1:0];
            default: mask = 4'b1111;
        endcase

        req.addr  = {addr[31:2], 2'b00};
        req.rmask = is_store ? 4'b0000 : mask;
        req.wmask = is_store ? mask : 4'b0000;
        req.wdata = '0;
        if (is_store)
        begin
            unique case (funct3[1:0])
                2'b00:   req.wdata[8*addr[1:0] +: 8] = st_entry.wdata[7:0];
                2'b01:   req.wdata[16*addr[1] +: 16] = st_entry.wdata[15:0];
                default: req.wdata = st_entry.wdata;
            endcase
        end
    end

    // response side, uses the access still in flight
    assign byte_v = rdata[8*resp_offset +: 8];
    assign half_v = rdata[16*resp_offset[1] +: 16];

    always_comb
    begin
        unique case (resp_funct3)
            F3_B:    load_value = {{24{byte_v[7]}}, byte_v};
            F3_BU:   load_value = {24'd0, byte_v};
            F3_H:    load_value = {{16{half_v[15]}}, half_v};
            F3_HU:   load_value = {16'd0, half_v};
            default: load_value = rdata;
        endcase
    end

endmodule

/* hdl/lsq_control.sv */
`timescale 1ns/10ps

module lsq_control
    import lsq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ld_ready,
    input  logic [LDQ_IDX_W-1:0] ld_idx,
    input  ldq_entry_t           ld_entry,
    input  logic                 st_ready,
    input  stq_entry_t           st_entry,
    input  mem_req_t             req_next,
    input  logic [31:0]          load_value,
    input  logic                 mem_resp,
    output mem_req_t             mem_req,
    output logic                 pick_store,
    output logic [2:0]           resp_funct3,
    output logic [1:0]           resp_offset,
    output logic                 load_done,
    output logic                 store_done,
    output logic [LDQ_IDX_W-1:0] done_idx,
    output result_t              result
);

    typedef enum logic {
        S_IDLE,
        S_WAIT
    } state_t;

    state_t               state;
    mem_req_t             req_q;
    result_t              res_q;
    logic                 launch;
    logic                 finish;
    // access in flight
    logic                 in_store;
    logic [ROB_W-1:0]     rob_q;
    logic [PHYS_W-1:0]    pd_q;
    logic [ARCH_W-1:0]    rd_q;
    logic [2:0]           f3_q;
    logic [1:0]           off_q;
    logic [LDQ_IDX_W-1:0] slot_q;

    // loads go first
    assign pick_store = !ld_ready;
    assign launch     = (state == S_IDLE) && (ld_ready || st_ready);
    assign finish     = (state == S_WAIT) && mem_resp;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= S_IDLE;
            req_q.rmask <= '0;
            req_q.wmask <= '0;
            res_q.valid <= 1'b0;
        end
        else
        begin
            res_q.valid <= finish;
            if (launch)
            begin
                state    <= S_WAIT;
                req_q    <= req_next;
                in_store <= pick_store;
                slot_q   <= ld_idx;
                if (pick_store)
                begin
                    rob_q <= st_entry.rob_num;
                    pd_q  <= st_entry.pd;
                    rd_q  <= st_entry.rd;
                    f3_q  <= st_entry.funct3;
                    off_q <= st_entry.addr[1:0];
                end
                else
                begin
                    rob_q <= ld_entry.rob_num;
                    pd_q  <= ld_entry.pd;
                    rd_q  <= ld_entry.rd;
                    f3_q  <= ld_entry.funct3;
                    off_q <= ld_entry.addr[1:0];
                end
            end
            else if (finish)
            begin
                state          <= S_IDLE;
                // drop the masks so the cache sees no new request
                req_q.rmask    <= '0;
                req_q.wmask    <= '0;
                res_q.is_store <= in_store;
                res_q.rob_num  <= rob_q;
                res_q.pd       <= pd_q;
                res_q.rd       <= rd_q;
                res_q.value    <= in_store ? 32'd0 : load_value;
            end
        end
    end

    assign mem_req     = req_q;
    assign result      = res_q;
    assign resp_funct3 = f3_q;
    assign resp_offset = off_q;
    assign done_idx    = slot_q;
    assign load_done   = finish && !in_store;
    assign store_done  = finish && in_store;

    req_held: assert property (@(posedge clk) disable iff (rst)
        (state == S_WAIT && !mem_resp) |=> $stable(mem_req));

endmodule

/* hdl/lsq_top.sv */
`timescale 1ns/10ps

module lsq_top
    import lsq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  dispatch_t   disp,
    input  addr_fill_t  fill,
    input  logic [31:0] mem_rdata,
    input  logic        mem_resp,
    output logic        full,
    output lsq_tag_t    alloc_tag,
    output mem_req_t    mem_req,
    output result_t     result
);

    logic                 ldq_full;
    logic                 stq_full;
    logic [LDQ_IDX_W-1:0] alloc_idx;
    logic [STQ_PTR_W-1:0] tail_idx;
    logic                 ld_ready;
    logic                 st_ready;
    logic [LDQ_IDX_W-1:0] ld_idx;
    ldq_entry_t           ld_entry;
    stq_entry_t           st_entry;
    logic [2:0]           load_count;
    logic [2:0]           stq_count;
    logic                 load_done;
    logic                 store_done;
    logic [LDQ_IDX_W-1:0] done_idx;
    logic                 pick_store;
    mem_req_t             req_next;
    logic [31:0]          load_value;
    logic [2:0]           resp_funct3;
    logic [1:0]           resp_offset;

    assign full               = ldq_full || stq_full;
    assign alloc_tag.is_store = (disp.opcode == OP_STORE);
    assign alloc_tag.idx      = alloc_tag.is_store ? tail_idx : alloc_idx;

    load_queue u_ldq (
        .clk        (clk),
        .rst        (rst),
        .disp       (disp),
        .fill       (fill),
        .store_done (store_done),
        .load_done  (load_done),
        .done_idx   (done_idx),
        .stq_count  (stq_count),
        .ldq_full   (ldq_full),
        .alloc_idx  (alloc_idx),
        .ready      (ld_ready),
        .sel_idx    (ld_idx),
        .sel_entry  (ld_entry),
        .load_count (load_count)
    );

    store_queue u_stq (
        .clk        (clk),
        .rst        (rst),
        .disp       (disp),
        .fill       (fill),
        .load_done  (load_done),
        .store_done (store_done),
        .load_count (load_count),
        .stq_full   (stq_full),
        .tail_idx   (tail_idx),
        .ready      (st_ready),
        .head_entry (st_entry),
        .stq_count  (stq_count)
    );

    mem_align u_align (
        .ld_entry    (ld_entry),
        .st_entry    (st_entry),
        .is_store    (pick_store),
        .rdata       (mem_rdata),
        .resp_funct3 (resp_funct3),
        .resp_offset (resp_offset),
        .req         (req_next),
        .load_value  (load_value)
    );

    lsq_control u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ld_ready    (ld_ready),
        .ld_idx      (ld_idx),
        .ld_entry    (ld_entry),
        .st_ready    (st_ready),
        .st_entry    (st_entry),
        .req_next    (req_next),
        .load_value  (load_value),
        .mem_resp    (mem_resp),
        .mem_req     (mem_req),
        .pick_store  (pick_store),
        .resp_funct3 (resp_funct3),
        .resp_offset (resp_offset),
        .load_done   (load_done),
        .store_done  (store_done),
        .done_idx    (done_idx),
        .result      (result)
    );

endmodule

/* bench/lsq_tb.sv */
`timescale 1ns/10ps

module lsq_tb
    import lsq_pkg::*;
();

    localparam int          N_INSTR      = 200;
    localparam logic [31:0] SEED         = 32'hc0ef;
    localparam logic [31:0] BASE         = 32'h0000_2000;
    localparam int          RESET_CYCLES = 16;
    localparam int          TIMEOUT_NS   = (RESET_CYCLES + N_INSTR * 40) * 100;

    logic       clk       = 1'b0;
    logic       rst       = 1'b1;
    dispatch_t  disp      = '0;
    addr_fill_t fill      = '0;
    logic [31:0] mem_rdata = '0;
    logic       mem_resp  = 1'b0;
    logic       full;
    lsq_tag_t   alloc_tag;
    mem_req_t   mem_req;
    result_t    result;

    // generated program and its reference values
    logic              p_store   [N_INSTR];
    logic [2:0]        p_f3      [N_INSTR];
    logic [31:0]       p_addr    [N_INSTR];
    logic [31:0]       p_wdata   [N_INSTR];
    logic [PHYS_W-1:0] p_pd      [N_INSTR];
    logic [ARCH_W-1:0] p_rd      [N_INSTR];
    lsq_tag_t          p_tag     [N_INSTR];
    logic [31:0]       ref_value [N_INSTR];

    // bookkeeping of what is in flight
    int          rob_owner [32];
    logic        slot_busy [LDQ_DEPTH];
    int          pend_fill [$];
    int          pend_delay [$];
    mem_req_t    req_log [$];
    int          ld_live    = 0;
    int          st_live    = 0;
    int          st_enq     = 0;
    int          done_count = 0;
    logic        hold_fills = 1'b1;
    logic        saw_full   = 1'b0;

    // cache model state
    logic [31:0] cache_mem [16];
    mem_req_t    held_req;
    logic        busy     = 1'b0;
    int          wait_cnt = 0;
    logic [31:0] cache_rs = SEED ^ 32'h00a5_5a00;
    logic [31:0] fill_rs  = SEED ^ 32'h3c00_0000;

    lsq_top dut (
        .clk       (clk),
        .rst       (rst),
        .disp      (disp),
        .fill      (fill),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp),
        .full      (full),
        .alloc_tag (alloc_tag),
        .mem_req   (mem_req),
        .result    (result)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // power-up memory contents, every address bit matters
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
    endfunction

    function automatic int size_of(input logic [2:0] f3);
        case (f3)
            F3_B, F3_BU: return 1;
            F3_H, F3_HU: return 2;
            default:     return 4;
        endcase
    endfunction

    // runs the program in order on a byte-wide shadow memory
    function automatic void run_reference();
        logic [7:0]  sh [64];
        logic [31:0] w;
        int          a;
        int          n;
        for (int k = 0; k < 16; k++)
        begin
            w = init_word(BASE + 32'(4 * k));
            for (int b = 0; b < 4; b++)
                sh[4 * k + b] = w[8 * b +: 8];
        end
        for (int i = 0; i < N_INSTR; i++)
        begin
            a = int'(p_addr[i] - BASE);
            n = size_of(p_f3[i]);
            w = '0;
            for (int b = 0; b < n; b++)
            begin
                if (p_store[i])
                    sh[a + b] = p_wdata[i][8 * b +: 8];
                else
                    w[8 * b +: 8] = sh[a + b];
            end
            // sign extension for the signed sizes
            if (p_f3[i] == F3_B && w[7])
                w[31:8] = '1;
            if (p_f3[i] == F3_H && w[15])
                w[31:16] = '1;
            ref_value[i] = w;
        end
    endfunction

    function automatic result_t expect_result(input int i);
        result_t r;
        r.valid    = 1'b1;
        r.is_store = p_store[i];
        r.rob_num  = ROB_W'(i);
        r.pd       = p_pd[i];
        r.rd       = p_rd[i];
        r.value    = ref_value[i];
        return r;
    endfunction

    function automatic mem_req_t expect_req(input int i);
        mem_req_t   r;
        logic [3:0] m;
        int         off;
        r   = '0;
        m   = '0;
        off = int'(p_addr[i][1:0]);
        r.addr = p_addr[i] & 32'hffff_fffc;
        for (int b = 0; b < size_of(p_f3[i]); b++)
        begin
            m[off + b] = 1'b1;
            if (p_store[i])
                r.wdata[8 * (off + b) +: 8] = p_wdata[i][8 * b +: 8];
        end
        if (p_store[i])
            r.wmask = m;
        else
            r.rmask = m;
        return r;
    endfunction

    // loads take the lowest free slot, stores the FIFO tail
    function automatic lsq_tag_t expect_tag(input int i);
        lsq_tag_t t;
        logic     found;
        t.is_store = p_store[i];
        t.idx      = LDQ_IDX_W'(st_enq % STQ_DEPTH);
        found      = 1'b0;
        if (!p_store[i])
        begin
            for (int s = 0; s < LDQ_DEPTH; s++)
            begin
                if (!found && !slot_busy[s])
                begin
                    t.idx = LDQ_IDX_W'(s);
                    found = 1'b1;
                end
            end
        end
        return t;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(input result_t got, input result_t exp, input string name);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp, input string name);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_tag(input lsq_tag_t got, input lsq_tag_t exp, input string name);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp));
    endtask

    initial
    begin
        logic [31:0] rs;
        lsq_tag_t    tag;
        int          word;
        int          i;
        rs = SEED;
        for (int k = 0; k < 32; k++)
            rob_owner[k] = -1;
        for (int s = 0; s < LDQ_DEPTH; s++)
            slot_busy[s] = 1'b0;
        for (int k = 0; k < 16; k++)
            cache_mem[k] = init_word(BASE + 32'(4 * k));

        // about 60% loads, naturally aligned in a 16-word window
        for (int n = 0; n < N_INSTR; n++)
        begin
            rs = xorshift(rs);
            p_store[n] = (rs % 10) < 4;
            word = int'(rs[11:8]);
            if (p_store[n])
            begin
                case (rs[17:16])
                    2'd0:    p_f3[n] = F3_B;
                    2'd1:    p_f3[n] = F3_H;
                    default: p_f3[n] = F3_W;
                endcase
            end
            else
            begin
                case (int'(rs[18:16]) % 5)
                    0:       p_f3[n] = F3_B;
                    1:       p_f3[n] = F3_H;
                    2:       p_f3[n] = F3_W;
                    3:       p_f3[n] = F3_BU;
                    default: p_f3[n] = F3_HU;
                endcase
            end
            p_addr[n] = BASE + 32'(4 * word);
            if (size_of(p_f3[n]) == 1)
                p_addr[n][1:0] = rs[21:20];
            else if (size_of(p_f3[n]) == 2)
                p_addr[n][1] = rs[20];
            rs = xorshift(rs);
            p_wdata[n] = rs;
            p_pd[n]    = rs[5:0];
            p_rd[n]    = rs[10:6];
        end
        run_reference();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag(full, 1'b0, "full");
        check_flag(|mem_req.rmask, 1'b0, "mem_req.rmask");
        check_flag(|mem_req.wmask, 1'b0, "mem_req.wmask");
        check_flag(result.valid, 1'b0, "result.valid");

        i = 0;
        while (i < N_INSTR)
        begin
            @(negedge clk);
            disp = '0;
            rs = xorshift(rs);
            if (!full && rs[1:0] != 2'b00)
            begin
                disp.valid   = 1'b1;
                disp.opcode  = p_store[i] ? OP_STORE : OP_LOAD;
                disp.funct3  = p_f3[i];
                disp.rob_num = ROB_W'(i);
                disp.pd      = p_pd[i];
                disp.rd      = p_rd[i];
                #1;
                tag = expect_tag(i);
                check_tag(alloc_tag, tag, "alloc_tag");
                @(posedge clk);
                if (rob_owner[i % 32] != -1)
                    fail_run("rob number handed out again while its older owner is in flight");
                rob_owner[i % 32] = i;
                p_tag[i] = tag;
                if (p_store[i])
                begin
                    st_enq++;
                    st_live++;
                end
                else
                begin
                    slot_busy[tag.idx] = 1'b1;
                    ld_live++;
                end
                pend_fill.push_back(i);
                pend_delay.push_back(int'(rs[12:8]) % 6);
                i++;
            end
        end
        @(negedge clk);
        disp = '0;

        while (done_count < N_INSTR)
            @(negedge clk);
        repeat (4) @(negedge clk);
        if (!saw_full)
            fail_run("full never rose while the address fills were held back");
        else if (req_log.size() != 0)
            fail_run("a memory access was answered without a matching result");
        else
        begin
            $display("No errors");
            $finish;
        end
    end

    // address adder model, releases ready fills in random order
    always @(negedge clk)
    begin
        int   n;
        int   j;
        int   pick;
        logic found;
        fill  = '0;
        found = 1'b0;
        // first burst runs with fills held back until the queues fill up
        if (!rst && hold_fills && full)
        begin
            saw_full   = 1'b1;
            hold_fills = 1'b0;
        end
        if (!rst && !hold_fills)
        begin
            for (int k = 0; k < pend_delay.size(); k++)
            begin
                if (pend_delay[k] > 0)
                    pend_delay[k]--;
            end
            n = pend_fill.size();
            fill_rs = xorshift(fill_rs);
            pick = (n > 0) ? int'(fill_rs % 32'(n)) : 0;
            for (int k = 0; k < n; k++)
            begin
                j = (pick + k) % n;
                if (!found && pend_delay[j] == 0)
                begin
                    found       = 1'b1;
                    fill.valid  = 1'b1;
                    fill.tag    = p_tag[pend_fill[j]];
                    fill.addr   = p_addr[pend_fill[j]];
                    fill.wdata  = p_store[pend_fill[j]] ? p_wdata[pend_fill[j]] : 32'd0;
                    pend_fill.delete(j);
                    pend_delay.delete(j);
                end
            end
        end
    end

    // data cache, answers after 1 to 4 cycles
    always @(negedge clk)
    begin
        logic [31:0] w;
        int          idx;
        mem_resp = 1'b0;
        cache_rs = xorshift(cache_rs);
        // garbage outside the response cycle
        mem_rdata = cache_rs;
        if (!rst && (mem_req.rmask != '0 || mem_req.wmask != '0))
        begin
            if (!busy)
            begin
                busy     = 1'b1;
                held_req = mem_req;
                wait_cnt = 1 + int'(cache_rs[1:0]);
                if (held_req.addr[31:6] != BASE[31:6])
                    fail_run("memory request addresses a word outside the test window");
                if (held_req.rmask != '0 && held_req.wmask != '0)
                    fail_run("memory request carries a read mask and a write mask");
            end
            else
                check_req(mem_req, held_req, "mem_req");
            if (wait_cnt == 1)
            begin
                idx = int'(held_req.addr[5:2]);
                w   = cache_mem[idx];
                mem_rdata = w;
                for (int b = 0; b < 4; b++)
                begin
                    if (held_req.wmask[b])
                        w[8 * b +: 8] = held_req.wdata[8 * b +: 8];
                end
                cache_mem[idx] = w;
                mem_resp = 1'b1;
                busy     = 1'b0;
                req_log.push_back(held_req);
            end
            else
                wait_cnt--;
        end
    end

    // matches each result to its instruction by rob number
    always @(negedge clk)
    begin
        int       idx;
        mem_req_t got_req;
        if (!rst)
        begin
            if (result.valid)
            begin
                idx = rob_owner[result.rob_num];
                if (idx < 0)
                    fail_run("result arrived for a rob number with nothing in flight");
                else if (req_log.size() == 0)
                    fail_run("result arrived before any memory access was answered");
                else
                begin
                    got_req = req_log.pop_front();
                    check_result(result, expect_result(idx), "result");
                    check_req(got_req, expect_req(idx), "mem_req");
                    rob_owner[result.rob_num] = -1;
                    if (p_store[idx])
                        st_live--;
                    else
                    begin
                        slot_busy[p_tag[idx].idx] = 1'b0;
                        ld_live--;
                    end
                    done_count++;
                end
            end
            check_flag(full, (ld_live == LDQ_DEPTH) || (st_live == STQ_DEPTH), "full");
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        fail_run("timeout: the instructions did not all complete in time");
    end

endmodule

/* split_lsq.f */
hdl/lsq_pkg.sv
hdl/load_queue.sv
hdl/store_queue.sv
hdl/mem_align.sv
hdl/lsq_control.sv
hdl/lsq_top.sv
bench/lsq_tb.sv

/* Makefile */
BIN  := obj_dir/Vlsq_tb
SRCS := $(shell cat split_lsq.f)

.PHONY: run clean

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "simulation FAILED"; exit 1; fi

$(BIN): split_lsq.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module lsq_tb \
		-Mdir obj_dir -f split_lsq.f

clean:
	rm -rf obj_dir sim.log
